//--- common/bp_cfg_pkg.sv
// branch predictor sizing
// history length, table size, pc hash offset and checkpoint queue depth

`default_nettype none

package bp_cfg_pkg;

	// global history bits, also the pattern table index width
	localparam int unsigned bh_size = 8;
	localparam int unsigned pht_entries = 2 ** bh_size; // one taken flag per entry

	localparam int unsigned pc_lsb = 2; // skip the byte offset

	// ordered branch queue
	localparam int unsigned obq_depth = 8;
	localparam int unsigned obq_ptr_w = $clog2(obq_depth);
	localparam int unsigned obq_cnt_w = $clog2(obq_depth + 1); // needs to hold depth itself

endpackage

`default_nettype wire

//--- common/bp_types_pkg.sv
// branch predictor bundles
// structs passed between fetch, checkpoint queue, predictor and execute

`default_nettype none

package bp_types_pkg;

	import bp_cfg_pkg::*;

	typedef logic [bh_size-1:0] history_t; // newest outcome in bit 0

	typedef struct packed {
		logic valid;
		logic [31:0] pc;
	} fetch_br_t;

	// state saved per predicted branch
	typedef struct packed {
		history_t history; // history before this branch was shifted in
		logic [31:0] pc;
		logic taken_pred;
	} checkpoint_t;

	// oldest branch outcome from execute
	typedef struct packed {
		logic valid;
		logic taken;
	} resolve_t;

	typedef struct packed {
		logic valid;
		history_t history; // checkpoint history
		logic [31:0] pc;   // checkpoint pc
		logic taken;       // actual outcome
	} recover_t;

endpackage

`default_nettype wire

//--- gshare/gshare.sv
// gshare direction predictor
// global history xor pc indexes a table of one-bit taken flags,
// speculative history update and repair from a checkpoint on mispredict

`default_nettype none

module gshare
	import bp_cfg_pkg::*;
	import bp_types_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        enable,           // queue has room for a checkpoint
	input  fetch_br_t   fetch_br,
	input  recover_t    recover,
	output logic        prediction_valid,
	output logic        prediction,
	output logic        push_valid,
	output checkpoint_t push
);

	history_t history;
	history_t next_history;
	logic [pht_entries-1:0] pht; // 0 not taken, 1 taken
	logic [pht_entries-1:0] next_pht;

	logic [bh_size-1:0] pc_bits;     // hashed fetch pc bits
	logic [bh_size-1:0] rec_pc_bits; // hashed pc of the branch being repaired
	logic [bh_size-1:0] hash_idx;
	logic [bh_size-1:0] rec_idx;

	assign pc_bits = fetch_br.pc[pc_lsb+bh_size-1:pc_lsb];
	assign rec_pc_bits = recover.pc[pc_lsb+bh_size-1:pc_lsb];

	assign hash_idx = history ^ pc_bits;
	assign rec_idx = recover.history ^ rec_pc_bits; // same entry the guess came from

	// lookup is purely combinational, same cycle as the fetch
	assign prediction = pht[hash_idx];

	// no guess while repairing or with the queue full
	assign prediction_valid = fetch_br.valid & enable & ~recover.valid;

	// every valid guess leaves a checkpoint of the pre-shift history
	assign push_valid = prediction_valid;
	assign push.history = history;
	assign push.pc = fetch_br.pc;
	assign push.taken_pred = prediction;

	always_comb begin
		next_pht = pht;
		next_history = history;

		if (recover.valid) begin
			// wrong guess, flip the flag so the next lookup goes the other way
			next_pht[rec_idx] = ~pht[rec_idx];
			// rebuild history as if the branch had been guessed right
			next_history = {recover.history[bh_size-2:0], recover.taken};
		end else if (prediction_valid) begin
			next_history = {history[bh_size-2:0], prediction}; // speculative shift
		end
		// correct resolutions leave the table alone
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pht <= '0; // every branch starts not taken
			history <= '0;
		end else begin
			pht <= next_pht;
			history <= next_history;
		end
	end

endmodule

`default_nettype wire

//--- src/branch_queue.sv
// ordered branch checkpoint queue
// holds one checkpoint per predicted branch, checks in-order resolutions
// against the stored guess and flushes younger entries on a mispredict

`default_nettype none

module branch_queue
	import bp_cfg_pkg::*;
	import bp_types_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        push_valid,
	input  checkpoint_t push,
	input  resolve_t    resolve,
	output logic        can_accept,  // enable for the predictor
	output logic        queue_full,
	output logic        mispredict,
	output recover_t    recover
);

	checkpoint_t entries [obq_depth]; // checkpoint storage indexed by head and tail

	logic [obq_ptr_w-1:0] head; // oldest branch
	logic [obq_ptr_w-1:0] tail; // next free slot
	logic [obq_cnt_w-1:0] count;

	logic full;
	logic empty;
	logic resolving;
	logic do_pop;
	logic do_push;
	checkpoint_t head_entry;

	// advance a pointer with wrap at the queue depth
	function automatic logic [obq_ptr_w-1:0] ptr_next(input logic [obq_ptr_w-1:0] ptr);
		logic [obq_ptr_w-1:0] nxt;
		if (ptr == obq_ptr_w'(obq_depth - 1))
			nxt = '0;
		else
			nxt = ptr + 1'b1;
		return nxt;
	endfunction

	assign full = (count == obq_cnt_w'(obq_depth));
	assign empty = (count == '0);

	assign queue_full = full;
	assign can_accept = ~full;

	assign head_entry = entries[head];

	// resolve on an empty queue is dropped
	assign resolving = resolve.valid & ~empty;
	assign mispredict = resolving & (head_entry.taken_pred != resolve.taken);
	assign do_pop = resolving & ~mispredict; // retire the head on a correct guess

	// wrong-path push in a mispredict cycle is thrown away
	assign do_push = push_valid & ~full & ~mispredict;

	// repair order carries the head checkpoint and the real outcome
	assign recover.valid = mispredict;
	assign recover.history = head_entry.history;
	assign recover.pc = head_entry.pc;
	assign recover.taken = resolve.taken;

	always_ff @(posedge clock) begin
		if (do_push)
			entries[tail] <= push;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else if (mispredict) begin
			// pop the head and flush all younger branches in one go
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_pop)
				head <= ptr_next(head);
			if (do_push)
				tail <= ptr_next(tail);

			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither keeps the count
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/bp_top.sv
// branch direction predictor top
// gshare predictor plus the checkpoint queue that feeds its repairs

`default_nettype none

module bp_top
	import bp_types_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  fetch_br_t fetch_br,   // from fetch
	input  resolve_t  resolve,    // from execute, oldest first
	output logic      prediction_valid,
	output logic      prediction,
	output logic      queue_full,
	output logic      mispredict
);

	recover_t    recover;     // queue to predictor repair order
	logic        can_accept;  // queue has room
	logic        push_valid;
	checkpoint_t push;        // predictor to queue checkpoint

	gshare gshare_inst (
		.clock            (clock),
		.reset            (reset),
		.enable           (can_accept),
		.fetch_br         (fetch_br),
		.recover          (recover),
		.prediction_valid (prediction_valid),
		.prediction       (prediction),
		.push_valid       (push_valid),
		.push             (push)
	);

	branch_queue branch_queue_inst (
		.clock      (clock),
		.reset      (reset),
		.push_valid (push_valid),
		.push       (push),
		.resolve    (resolve),
		.can_accept (can_accept),
		.queue_full (queue_full),
		.mispredict (mispredict),
		.recover    (recover)
	);

endmodule

`default_nettype wire

//--- tb/tb_bp_top.sv
// testbench for the branch direction predictor
// replays per-cycle fetch and resolve stimulus from a case file and checks every output

`default_nettype none

module tb_bp_top
	import bp_types_pkg::*;
();

	localparam string case_path = "tb/bp_cases.txt";

	logic clock = 1'b0;
	logic reset;
	fetch_br_t fetch_br;
	resolve_t resolve;
	logic prediction_valid;
	logic prediction;
	logic queue_full;
	logic mispredict;

	int watchdog_limit;
	logic limit_ready = 1'b0; // watchdog starts once the case file is sized

	string test_name;         // test currently running
	logic test_open = 1'b0;
	int test_errors;
	int test_count;
	int cycle_count;
	int total_errors;

	bp_top bp_top_inst (
		.clock            (clock),
		.reset            (reset),
		.fetch_br         (fetch_br),
		.resolve          (resolve),
		.prediction_valid (prediction_valid),
		.prediction       (prediction),
		.queue_full       (queue_full),
		.mispredict       (mispredict)
	);

	always #2 clock = ~clock; // period 4

	// counts case file lines and returns -1 when the file cannot be opened
	task automatic count_lines(output int n);
		int fd;
		int ch;
		fd = $fopen(case_path, "r");
		if (fd == 0) begin
			n = -1;
		end else begin
			n = 0;
			ch = $fgetc(fd);
			while (ch != -1) begin
				if (ch == 10) // newline
					n++;
				ch = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	// drop the rest of a comment line
	task automatic skip_line(input int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != 10 && ch != -1)
			ch = $fgetc(fd);
	endtask

	task automatic check_signal(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s in %s expected %0b got %0b",
				$time, name, test_name, expected, actual);
			test_errors++;
			total_errors++;
		end
	endtask

	// one report line per finished test
	task automatic close_test();
		if (test_open) begin
			$display("test %s done, %0d errors", test_name, test_errors);
			test_count++;
			test_open = 1'b0;
		end
	endtask

	// drive just after the edge and check just before the next one
	task automatic apply_cycle(input int fv, input logic [31:0] pc, input int rv,
			input int rt, input int e_pv, input int e_pred, input int e_mis,
			input int e_full);
		@(posedge clock);
		#1;
		fetch_br.valid = fv[0];
		fetch_br.pc = pc;
		resolve.valid = rv[0];
		resolve.taken = rt[0];
		#2;
		check_signal("prediction_valid", prediction_valid, e_pv[0]);
		check_signal("prediction", prediction, e_pred[0]);
		check_signal("mispredict", mispredict, e_mis[0]);
		check_signal("queue_full", queue_full, e_full[0]);
		cycle_count++;
	endtask

	task automatic run_cases();
		int fd;
		int code;
		string tag;
		int fv;
		logic [31:0] pc;
		int rv;
		int rt;
		int e_pv;
		int e_pred;
		int e_mis;
		int e_full;
		fd = $fopen(case_path, "r");
		code = $fscanf(fd, "%s", tag);
		while (code == 1) begin
			if (tag == "#") begin
				skip_line(fd);
			end else if (tag == "test") begin
				close_test(); // marker closes the previous test
				code = $fscanf(fd, "%s", test_name);
				test_errors = 0;
				test_open = 1'b1;
			end else if (tag == "c") begin
				code = $fscanf(fd, "%d %h %d %d %d %d %d %d",
					fv, pc, rv, rt, e_pv, e_pred, e_mis, e_full);
				if (code != 8) begin
					$display("a cycle line in the case file is incomplete");
					total_errors++;
				end else begin
					apply_cycle(fv, pc, rv, rt, e_pv, e_pred, e_mis, e_full);
				end
			end else begin
				$display("the case file holds an unknown line starting with %s", tag);
				total_errors++;
				skip_line(fd);
			end
			code = $fscanf(fd, "%s", tag);
		end
		close_test(); // last test ends with the file
		$fclose(fd);
	endtask

	initial begin
		int line_count;
		reset = 1'b1;
		fetch_br = '0;
		resolve = '0;
		test_errors = 0;
		test_count = 0;
		cycle_count = 0;
		total_errors = 0;
		test_name = "none";
		count_lines(line_count);
		if (line_count < 0) begin
			$display("the case file %s could not be opened", case_path);
			$display("Test failed");
			$finish;
		end else begin
			watchdog_limit = 4 * line_count * 4 + 100;
			limit_ready = 1'b1;
			repeat (3) @(posedge clock);
			#1 reset = 1'b0;
			run_cases();
			$display("tests %0d, cycles %0d, errors %0d", test_count, cycle_count, total_errors);
			if (total_errors == 0)
				$display("Test completed successfully");
			else
				$display("Test failed");
			$finish;
		end
	end

	// ends a run that stopped making progress
	initial begin
		wait (limit_ready);
		#(watchdog_limit);
		$display("timeout, the run did not finish within %0d time units", watchdog_limit);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/bp_cases.txt
# c fetch_valid pc(hex) resolve_valid resolve_taken then expected prediction_valid
# prediction mispredict queue_full; a line "test <name>" starts a new test
test reset_first_branch
c 0 00000000 0 0 0 0 0 0
c 1 00000100 0 0 1 0 0 0
c 0 00000000 0 0 0 0 0 0
test correct_not_taken
c 0 00000000 1 0 0 0 0 0
c 1 00000100 0 0 1 0 0 0
c 0 00000000 1 0 0 0 0 0
test mispredict_repair
c 1 00000100 0 0 1 0 0 0
c 1 00000200 1 1 0 0 1 0
c 1 000003fc 0 0 1 0 0 0
c 1 000003fc 1 0 1 0 0 0
c 1 000003fc 1 0 1 0 0 0
c 1 000003fc 1 0 1 0 0 0
c 1 000003fc 1 0 1 0 0 0
c 1 000003fc 1 0 1 0 0 0
c 1 000003fc 1 0 1 0 0 0
c 1 000003fc 1 0 1 0 0 0
test hash_separate_entries
c 1 00000104 1 0 1 0 0 0
c 1 00000100 1 0 1 1 0 0
c 0 00000000 1 1 0 0 0 0
test queue_full
c 1 000003fc 0 0 1 0 0 0
c 1 000003fc 0 0 1 0 0 0
c 1 000003fc 0 0 1 0 0 0
c 1 000003fc 0 0 1 0 0 0
c 1 000003fc 0 0 1 0 0 0
c 1 000003fc 0 0 1 0 0 0
c 1 000003fc 0 0 1 0 0 0
c 1 000003fc 0 0 1 0 0 0
c 1 000003fc 0 0 0 0 0 1
c 1 000003fc 1 0 0 0 0 1
c 1 000003fc 0 0 1 0 0 0
test mispredict_flush
c 0 00000000 1 1 0 0 1 1
c 0 00000000 1 0 0 0 0 0
c 1 000003e0 0 0 1 1 0 0
c 0 00000000 1 1 0 0 0 0

//--- verilog.f
common/bp_cfg_pkg.sv
common/bp_types_pkg.sv
gshare/gshare.sv
src/branch_queue.sv
src/bp_top.sv
tb/tb_bp_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the branch predictor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_bp_top -f verilog.f \
	&& sim_out="$(./obj_dir/Vtb_bp_top)" \
	|| { echo "build or simulation run failed"; exit 1; }

echo "$sim_out"
echo "$sim_out" | grep -qF "Test completed successfully" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
